//--- filelist.f
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_muldiv.sv
hdl/exec_branch_unit.sv
hdl/exec_result_select.sv
hdl/exec_multicycle_ctrl.sv
hdl/exec_stage.sv
tests/exec_stage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - hdl/exec_pkg.sv
      - hdl/exec_alu.sv
      - hdl/exec_muldiv.sv
      - hdl/exec_branch_unit.sv
      - hdl/exec_result_select.sv
      - hdl/exec_multicycle_ctrl.sv
      - hdl/exec_stage.sv
  - target: test
    files:
      - tests/exec_stage_tb.sv

//--- tests/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb;

	localparam int LATENCY    = exec_pkg::MUL_CYCLES;
	localparam int VEC_PER_OP = 6;
	localparam int N_VECTORS  = 42 * VEC_PER_OP + 14; // sweeps, edge cases, bubbles
	localparam int MAX_CYCLES = N_VECTORS * (LATENCY + 3) + 200;

	logic                            i_clk;
	logic                            rst;
	logic [exec_pkg::N_OPS-1:0]      op;
	logic [exec_pkg::REG_ADDR_W-1:0] rd;
	logic [exec_pkg::XLEN-1:0]       operand1;
	logic [exec_pkg::XLEN-1:0]       operand2;
	logic [exec_pkg::XLEN-1:0]       imm;
	logic [exec_pkg::XLEN-1:0]       pc;
	logic [exec_pkg::XLEN-1:0]       csr_rdata;
	logic                            rs_valid;
	logic                            mem_ready;
	logic [exec_pkg::XLEN-1:0]       result_1;
	logic [exec_pkg::XLEN-1:0]       result_2;
	logic                            branch_taken;
	logic                            jump;
	logic                            write_reg;
	logic                            write_csr;
	logic                            stall;

	int          cur_idx;
	logic [31:0] exp_r1;
	logic [31:0] exp_r2;
	logic        exp_stall;
	logic        m_issue;
	int          md_phase;
	int          err_count     = 0;
	int          tests_run     = 0;
	int          tests_failed  = 0;
	int          test_err_base = 0;
	int          cycle_count   = 0;
	string       test_name;

	exec_stage dut_i (
		.i_clk(i_clk), .rst(rst), .op_i(op), .rd_i(rd), .operand1_i(operand1),
		.operand2_i(operand2), .imm_i(imm), .pc_i(pc), .csr_rdata_i(csr_rdata),
		.rs_valid_i(rs_valid), .mem_ready_i(mem_ready), .result_1_o(result_1),
		.result_2_o(result_2), .branch_taken_o(branch_taken), .jump_o(jump),
		.write_reg_o(write_reg), .write_csr_o(write_csr), .stall_o(stall)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	function automatic logic [exec_pkg::N_OPS-1:0] op_vector(input int idx);
		if (idx < 0) return '0;
		return exec_pkg::N_OPS'(1) << idx;
	endfunction

	function automatic int op_index(input logic [exec_pkg::N_OPS-1:0] v);
		int idx;
		idx = -1;
		for (int k = 0; k < exec_pkg::N_OPS; k++) begin
			if (v[k]) idx = k;
		end
		return idx;
	endfunction

	function automatic logic is_branch(input int idx);
		return idx inside {exec_pkg::OP_BEQ, exec_pkg::OP_BNE, exec_pkg::OP_BLT,
			exec_pkg::OP_BGE, exec_pkg::OP_BLTU, exec_pkg::OP_BGEU};
	endfunction

	function automatic logic is_csr(input int idx);
		return idx inside {exec_pkg::OP_CSRRW, exec_pkg::OP_CSRRS, exec_pkg::OP_CSRRC};
	endfunction

	function automatic logic is_md(input int idx);
		return idx inside {exec_pkg::OP_MUL, exec_pkg::OP_MULH, exec_pkg::OP_MULHSU,
			exec_pkg::OP_MULHU, exec_pkg::OP_DIV, exec_pkg::OP_DIVU, exec_pkg::OP_REM,
			exec_pkg::OP_REMU};
	endfunction

	function automatic logic is_jump(input int idx);
		return idx == exec_pkg::OP_JAL || idx == exec_pkg::OP_JALR;
	endfunction

	function automatic logic branch_cond(input int idx, input logic [31:0] a, b);
		case (idx)
			exec_pkg::OP_BEQ:  return a == b;
			exec_pkg::OP_BNE:  return a != b;
			exec_pkg::OP_BLT:  return $signed(a) < $signed(b);
			exec_pkg::OP_BGE:  return $signed(a) >= $signed(b);
			exec_pkg::OP_BLTU: return a < b;
			exec_pkg::OP_BGEU: return a >= b;
			default:           return 1'b0;
		endcase
	endfunction

	// high words built from the unsigned product with sign corrections
	function automatic logic [31:0] md_value(input int idx, input logic [31:0] a, b);
		logic [63:0] uu;
		logic        ovf;
		int          sa;
		int          sb;
		uu  = {32'b0, a} * {32'b0, b};
		ovf = (a == exec_pkg::INT_MIN_VALUE) && (b == 32'hffff_ffff);
		sa  = a;
		sb  = b;
		case (idx)
			exec_pkg::OP_MUL:    return uu[31:0];
			exec_pkg::OP_MULHU:  return uu[63:32];
			exec_pkg::OP_MULHSU: return uu[63:32] - (a[31] ? b : 32'd0);
			exec_pkg::OP_MULH:   return uu[63:32] - (a[31] ? b : 32'd0) - (b[31] ? a : 32'd0);
			exec_pkg::OP_DIV: begin
				if (b == 0) return 32'hffff_ffff;
				if (ovf) return a;
				return sa / sb;
			end
			exec_pkg::OP_DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
			exec_pkg::OP_REM: begin
				if (b == 0) return a;
				if (ovf) return 32'd0;
				return sa % sb; // sign follows the dividend
			end
			exec_pkg::OP_REMU:   return (b == 0) ? a : a % b;
			default:             return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] primary_value(input int idx,
			input logic [31:0] a, b, i, p, c);
		if (is_branch(idx)) return {31'b0, branch_cond(idx, a, b)};
		if (is_jump(idx)) return p + 32'd4;
		if (is_csr(idx)) return c;
		if (is_md(idx)) return md_value(idx, a, b);
		case (idx)
			exec_pkg::OP_ADD:   return a + b;
			exec_pkg::OP_SUB:   return a - b;
			exec_pkg::OP_XOR:   return a ^ b;
			exec_pkg::OP_OR:    return a | b;
			exec_pkg::OP_AND:   return a & b;
			exec_pkg::OP_SLL:   return a << b[4:0];
			exec_pkg::OP_SRL:   return a >> b[4:0];
			exec_pkg::OP_SRA:   return $signed(a) >>> b[4:0];
			exec_pkg::OP_SLT:   return {31'b0, $signed(a) < $signed(b)};
			exec_pkg::OP_SLTU:  return {31'b0, a < b};
			exec_pkg::OP_XORI:  return a ^ i;
			exec_pkg::OP_ORI:   return a | i;
			exec_pkg::OP_ANDI:  return a & i;
			exec_pkg::OP_SLLI:  return a << i[4:0];
			exec_pkg::OP_SRLI:  return a >> i[4:0];
			exec_pkg::OP_SRAI:  return $signed(a) >>> i[4:0];
			exec_pkg::OP_SLTI:  return {31'b0, $signed(a) < $signed(i)};
			exec_pkg::OP_SLTIU: return {31'b0, a < i};
			exec_pkg::OP_LUI:   return i;
			exec_pkg::OP_AUIPC: return p + i;
			exec_pkg::OP_ADDI, exec_pkg::OP_LOAD, exec_pkg::OP_STORE: return a + i;
			default:            return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] secondary_value(input int idx,
			input logic [31:0] a, i, p, c);
		if (idx == exec_pkg::OP_JALR) return a + i;
		if (is_branch(idx) || idx == exec_pkg::OP_JAL) return p + i;
		if (idx == exec_pkg::OP_CSRRW) return a;
		if (idx == exec_pkg::OP_CSRRS) return a | c;
		if (idx == exec_pkg::OP_CSRRC) return c & ~a;
		return 32'd0;
	endfunction

	always_comb begin
		cur_idx = op_index(op);
		exp_r1  = primary_value(cur_idx, operand1, operand2, imm, pc, csr_rdata);
		exp_r2  = secondary_value(cur_idx, operand1, imm, pc, csr_rdata);
	end

	// stall model: phase 1..LATENCY-1 counting, LATENCY waits for memory
	assign m_issue   = is_md(cur_idx) && rs_valid && md_phase == 0;
	assign exp_stall = m_issue || (md_phase > 0 && md_phase < LATENCY) || !rs_valid || !mem_ready;

	always_ff @(posedge i_clk) begin
		if (rst) md_phase <= 0;
		else if (m_issue) md_phase <= 1;
		else if (md_phase > 0 && md_phase < LATENCY) md_phase <= md_phase + 1;
		else if (md_phase == LATENCY && mem_ready) md_phase <= 0;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp, act);
		$display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
		err_count++;
	endtask

	a_result_1: assert property (@(posedge i_clk) disable iff (rst)
		cur_idx < 0 || result_1 == exp_r1)
		else report_mismatch("result_1_o", $sampled(exp_r1), $sampled(result_1));
	a_result_2: assert property (@(posedge i_clk) disable iff (rst)
		!(is_branch(cur_idx) || is_jump(cur_idx) || is_csr(cur_idx)) || result_2 == exp_r2)
		else report_mismatch("result_2_o", $sampled(exp_r2), $sampled(result_2));
	a_taken: assert property (@(posedge i_clk) disable iff (rst)
		branch_taken == (is_branch(cur_idx) && branch_cond(cur_idx, operand1, operand2)))
		else report_mismatch("branch_taken_o", !$sampled(branch_taken), $sampled(branch_taken));
	a_jump: assert property (@(posedge i_clk) disable iff (rst)
		jump == is_jump(cur_idx))
		else report_mismatch("jump_o", !$sampled(jump), $sampled(jump));
	a_write_reg: assert property (@(posedge i_clk) disable iff (rst)
		write_reg == (cur_idx >= 0 && cur_idx != exec_pkg::OP_STORE && !is_branch(cur_idx)
			&& rd != 0))
		else report_mismatch("write_reg_o", !$sampled(write_reg), $sampled(write_reg));
	a_write_csr: assert property (@(posedge i_clk) disable iff (rst)
		write_csr == is_csr(cur_idx))
		else report_mismatch("write_csr_o", !$sampled(write_csr), $sampled(write_csr));
	a_stall: assert property (@(posedge i_clk) disable iff (rst)
		stall == exp_stall)
		else report_mismatch("stall_o", $sampled(exp_stall), $sampled(stall));

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not end within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// called on a rising edge, returns on the edge after a stall-free cycle
	task automatic drive_vector(input int idx, input logic [4:0] dest,
			input logic [31:0] a, b, i, p, c);
		op        <= op_vector(idx);
		rd        <= dest;
		operand1  <= a;
		operand2  <= b;
		imm       <= i;
		pc        <= p;
		csr_rdata <= c;
		@(posedge i_clk);
		while (stall) @(posedge i_clk);
	endtask

	task automatic drive_random(input int idx);
		logic [31:0] a;
		logic [31:0] b;
		for (int j = 0; j < VEC_PER_OP; j++) begin
			a = $urandom;
			b = (j % 3 == 1) ? a : $urandom; // equal operands now and then
			drive_vector(idx, (j == 0) ? 5'd0 : 5'($urandom_range(31, 1)), a, b,
				$urandom, $urandom, $urandom);
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = err_count;
		tests_run++;
	endtask

	task automatic end_test();
		op <= '0; // idle bubble, flags must stay low
		@(posedge i_clk);
		@(negedge i_clk);
		if (err_count != test_err_base) begin
			tests_failed++;
			$display("test %s: FAILED, %0d mismatches", test_name, err_count - test_err_base);
		end else begin
			$display("test %s: passed", test_name);
		end
		@(posedge i_clk);
	endtask

	task automatic backpressure_check();
		begin_test("backpressure");
		op       <= op_vector(exec_pkg::OP_MUL);
		operand1 <= $urandom;
		operand2 <= $urandom;
		repeat (LATENCY - 2) @(posedge i_clk);
		mem_ready <= 1'b0; // still low when the count completes
		repeat (4) @(posedge i_clk);
		mem_ready <= 1'b1;
		@(posedge i_clk);
		while (stall) @(posedge i_clk);
		op       <= op_vector(exec_pkg::OP_DIVU);
		rs_valid <= 1'b0;
		repeat (3) @(posedge i_clk);
		rs_valid <= 1'b1;
		@(posedge i_clk);
		while (stall) @(posedge i_clk);
		end_test();
	endtask

	initial begin
		void'($urandom(32'h2aad));
		rst       <= 1'b1;
		op        <= '0;
		rd        <= '0;
		operand1  <= '0;
		operand2  <= '0;
		imm       <= '0;
		pc        <= '0;
		csr_rdata <= '0;
		rs_valid  <= 1'b1;
		mem_ready <= 1'b1;
		repeat (2) @(posedge i_clk);
		rst <= 1'b0;

		begin_test("alu");
		for (int k = exec_pkg::OP_ADD; k <= exec_pkg::OP_SLTIU; k++) drive_random(k);
		end_test();

		begin_test("load_store_upper");
		drive_random(exec_pkg::OP_LOAD);
		drive_random(exec_pkg::OP_STORE);
		drive_random(exec_pkg::OP_LUI);
		drive_random(exec_pkg::OP_AUIPC);
		end_test();

		begin_test("branch_jump");
		for (int k = exec_pkg::OP_BEQ; k <= exec_pkg::OP_JALR; k++) drive_random(k);
		end_test();

		begin_test("csr");
		for (int k = exec_pkg::OP_CSRRW; k <= exec_pkg::OP_CSRRC; k++) drive_random(k);
		end_test();

		begin_test("muldiv");
		for (int k = exec_pkg::OP_MUL; k <= exec_pkg::OP_REMU; k++) drive_random(k);
		drive_vector(exec_pkg::OP_DIV, 5'd1, 32'h1234_5678, 32'd0, 0, 0, 0);
		drive_vector(exec_pkg::OP_DIVU, 5'd2, 32'hdead_beef, 32'd0, 0, 0, 0);
		drive_vector(exec_pkg::OP_REM, 5'd3, 32'h8765_4321, 32'd0, 0, 0, 0);
		drive_vector(exec_pkg::OP_REMU, 5'd4, 32'h0bad_f00d, 32'd0, 0, 0, 0);
		drive_vector(exec_pkg::OP_DIV, 5'd5, exec_pkg::INT_MIN_VALUE, 32'hffff_ffff, 0, 0, 0);
		drive_vector(exec_pkg::OP_REM, 5'd6, exec_pkg::INT_MIN_VALUE, 32'hffff_ffff, 0, 0, 0);
		end_test();

		backpressure_check();

		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input  logic                            i_clk,
	input  logic                            rst,
	input  logic [exec_pkg::N_OPS-1:0]      op_i,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic [exec_pkg::XLEN-1:0]       operand1_i,
	input  logic [exec_pkg::XLEN-1:0]       operand2_i,
	input  logic [exec_pkg::XLEN-1:0]       imm_i,
	input  logic [exec_pkg::XLEN-1:0]       pc_i,
	input  logic [exec_pkg::XLEN-1:0]       csr_rdata_i,
	input  logic                            rs_valid_i,
	input  logic                            mem_ready_i,
	output logic [exec_pkg::XLEN-1:0]       result_1_o,
	output logic [exec_pkg::XLEN-1:0]       result_2_o,
	output logic                            branch_taken_o,
	output logic                            jump_o,
	output logic                            write_reg_o,
	output logic                            write_csr_o,
	output logic                            stall_o
);

	logic [exec_pkg::XLEN-1:0] alu_result;
	logic [exec_pkg::XLEN-1:0] md_result;
	logic                      cond;
	logic [exec_pkg::XLEN-1:0] target;
	logic [exec_pkg::XLEN-1:0] link;

	exec_alu alu_i (
		.op_i(op_i), .operand1_i(operand1_i), .operand2_i(operand2_i),
		.imm_i(imm_i), .pc_i(pc_i), .alu_result_o(alu_result)
	);

	exec_muldiv muldiv_i (
		.op_i(op_i), .operand1_i(operand1_i), .operand2_i(operand2_i),
		.md_result_o(md_result)
	);

	exec_branch_unit branch_i (
		.op_i(op_i), .operand1_i(operand1_i), .operand2_i(operand2_i),
		.imm_i(imm_i), .pc_i(pc_i), .cond_o(cond), .target_o(target), .link_o(link)
	);

	exec_result_select select_i (
		.op_i(op_i), .rd_i(rd_i), .operand1_i(operand1_i), .csr_rdata_i(csr_rdata_i),
		.alu_result_i(alu_result), .md_result_i(md_result), .cond_i(cond),
		.target_i(target), .link_i(link), .result_1_o(result_1_o), .result_2_o(result_2_o),
		.branch_taken_o(branch_taken_o), .jump_o(jump_o), .write_reg_o(write_reg_o),
		.write_csr_o(write_csr_o)
	);

	exec_multicycle_ctrl ctrl_i (
		.i_clk(i_clk), .rst(rst), .op_i(op_i), .rs_valid_i(rs_valid_i),
		.mem_ready_i(mem_ready_i), .stall_o(stall_o)
	);

endmodule

//--- hdl/exec_multicycle_ctrl.sv
`timescale 1ns/1ps

module exec_multicycle_ctrl (
	input  logic                       i_clk,
	input  logic                       rst,
	input  logic [exec_pkg::N_OPS-1:0] op_i,
	input  logic                       rs_valid_i,
	input  logic                       mem_ready_i,
	output logic                       stall_o
);

	logic [1:0]                 state_q;
	logic [1:0]                 state_d;
	logic [exec_pkg::CNT_W-1:0] cnt_q;
	logic [exec_pkg::CNT_W-1:0] cnt_d;
	logic                       start;
	logic                       cnt_done;
	logic                       busy;

	assign start    = (|op_i[exec_pkg::OP_REMU:exec_pkg::OP_MUL]) & rs_valid_i;
	assign cnt_done = (cnt_q == exec_pkg::MUL_CYCLES);

	always_comb begin
		state_d = state_q;
		cnt_d   = exec_pkg::CNT_W'(1);
		busy    = 1'b0;
		case (state_q)
			exec_pkg::ST_IDLE: begin
				if (start) begin
					busy    = 1'b1; // stall already in the issue cycle
					state_d = exec_pkg::ST_COUNT;
				end
			end
			exec_pkg::ST_COUNT: begin
				if (cnt_done) begin
					if (mem_ready_i) begin
						state_d = exec_pkg::ST_IDLE;
					end else begin
						busy    = 1'b1;
						state_d = exec_pkg::ST_HOLD;
					end
				end else begin
					busy  = 1'b1;
					cnt_d = cnt_q + 1'b1;
				end
			end
			exec_pkg::ST_HOLD: begin
				if (mem_ready_i) state_d = exec_pkg::ST_IDLE;
				else busy = 1'b1; // result waits for memory stage
			end
			default: state_d = exec_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (rst) begin
			state_q <= exec_pkg::ST_IDLE;
			cnt_q   <= exec_pkg::CNT_W'(1);
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
		end
	end

	assign stall_o = busy | ~rs_valid_i | ~mem_ready_i;

	a_cnt_range: assert property (@(posedge i_clk) disable iff (rst)
		cnt_q <= exec_pkg::MUL_CYCLES);

	// issue cycle plus the count keep the pipe stalled for the full latency
	a_stall_len: assert property (@(posedge i_clk) disable iff (rst)
		(state_q == exec_pkg::ST_IDLE && start) |-> stall_o [*exec_pkg::MUL_CYCLES]);

endmodule

//--- hdl/exec_result_select.sv
`timescale 1ns/1ps

module exec_result_select (
	input  logic [exec_pkg::N_OPS-1:0]      op_i,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic [exec_pkg::XLEN-1:0]       operand1_i,
	input  logic [exec_pkg::XLEN-1:0]       csr_rdata_i,
	input  logic [exec_pkg::XLEN-1:0]       alu_result_i,
	input  logic [exec_pkg::XLEN-1:0]       md_result_i,
	input  logic                            cond_i,
	input  logic [exec_pkg::XLEN-1:0]       target_i,
	input  logic [exec_pkg::XLEN-1:0]       link_i,
	output logic [exec_pkg::XLEN-1:0]       result_1_o,
	output logic [exec_pkg::XLEN-1:0]       result_2_o,
	output logic                            branch_taken_o,
	output logic                            jump_o,
	output logic                            write_reg_o,
	output logic                            write_csr_o
);

	logic is_branch;
	logic is_jump;
	logic is_csr;
	logic is_md;
	logic is_store;
	logic any_op;

	// groups are contiguous in the op vector
	assign is_branch = |op_i[exec_pkg::OP_BGEU:exec_pkg::OP_BEQ];
	assign is_jump   = op_i[exec_pkg::OP_JAL] | op_i[exec_pkg::OP_JALR];
	assign is_csr    = |op_i[exec_pkg::OP_CSRRC:exec_pkg::OP_CSRRW];
	assign is_md     = |op_i[exec_pkg::OP_REMU:exec_pkg::OP_MUL];
	assign is_store  = op_i[exec_pkg::OP_STORE];
	assign any_op    = |op_i;

	always_comb begin
		if (is_branch)   result_1_o = {{(exec_pkg::XLEN-1){1'b0}}, cond_i};
		else if (is_jump) result_1_o = link_i;
		else if (is_csr)  result_1_o = csr_rdata_i; // old csr value goes to rd
		else if (is_md)   result_1_o = md_result_i;
		else              result_1_o = alu_result_i;
	end

	// new csr value or control transfer target
	always_comb begin
		result_2_o = '0;
		if (is_branch || is_jump) result_2_o = target_i;
		else if (op_i[exec_pkg::OP_CSRRW]) result_2_o = operand1_i;
		else if (op_i[exec_pkg::OP_CSRRS]) result_2_o = operand1_i | csr_rdata_i;
		else if (op_i[exec_pkg::OP_CSRRC]) result_2_o = csr_rdata_i & ~operand1_i;
	end

	assign branch_taken_o = is_branch & cond_i;
	assign jump_o         = is_jump;
	assign write_csr_o    = is_csr;
	assign write_reg_o    = any_op & ~is_store & ~is_branch & (rd_i != '0); // x0 never written

	// decode must hand over a one-hot vector
	a_op_onehot: assert final ($onehot0(op_i))
		else $error("exec: more than one operation bit set %h", op_i);

endmodule

//--- hdl/exec_branch_unit.sv
`timescale 1ns/1ps

module exec_branch_unit (
	input  logic [exec_pkg::N_OPS-1:0] op_i,
	input  logic [exec_pkg::XLEN-1:0]  operand1_i,
	input  logic [exec_pkg::XLEN-1:0]  operand2_i,
	input  logic [exec_pkg::XLEN-1:0]  imm_i,
	input  logic [exec_pkg::XLEN-1:0]  pc_i,
	output logic                       cond_o,
	output logic [exec_pkg::XLEN-1:0]  target_o,
	output logic [exec_pkg::XLEN-1:0]  link_o
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (operand1_i == operand2_i);
	assign lt_s = $signed(operand1_i) < $signed(operand2_i);
	assign lt_u = operand1_i < operand2_i;

	always_comb begin
		cond_o = 1'b0;
		if (op_i[exec_pkg::OP_BEQ]) begin
			cond_o = eq;
		end else if (op_i[exec_pkg::OP_BNE]) begin
			cond_o = ~eq;
		end else if (op_i[exec_pkg::OP_BLT]) begin
			cond_o = lt_s;
		end else if (op_i[exec_pkg::OP_BGE]) begin
			cond_o = ~lt_s;
		end else if (op_i[exec_pkg::OP_BLTU]) begin
			cond_o = lt_u;
		end else if (op_i[exec_pkg::OP_BGEU]) begin
			cond_o = ~lt_u;
		end
	end

	// jalr is register relative, everything else pc relative
	assign target_o = op_i[exec_pkg::OP_JALR] ? operand1_i + imm_i : pc_i + imm_i;

	assign link_o = pc_i + exec_pkg::LINK_OFFSET; // return address

endmodule

//--- hdl/exec_muldiv.sv
`timescale 1ns/1ps

module exec_muldiv (
	input  logic [exec_pkg::N_OPS-1:0] op_i,
	input  logic [exec_pkg::XLEN-1:0]  operand1_i,
	input  logic [exec_pkg::XLEN-1:0]  operand2_i,
	output logic [exec_pkg::XLEN-1:0]  md_result_o
);

	localparam int W = exec_pkg::XLEN;

	logic signed [2*W-1:0] prod_ss;
	logic signed [2*W-1:0] prod_su;
	logic        [2*W-1:0] prod_uu;
	logic                  div_by_zero;
	logic                  div_overflow;
	logic        [W-1:0]   divisor;
	logic        [W-1:0]   quot_s;
	logic        [W-1:0]   rem_s;
	logic        [W-1:0]   quot_u;
	logic        [W-1:0]   rem_u;

	// 64-bit products, operands widened by hand
	assign prod_ss = $signed({{W{operand1_i[W-1]}}, operand1_i}) *
	                 $signed({{W{operand2_i[W-1]}}, operand2_i});
	assign prod_su = $signed({{W{operand1_i[W-1]}}, operand1_i}) *
	                 $signed({{W{1'b0}}, operand2_i});
	assign prod_uu = {{W{1'b0}}, operand1_i} * {{W{1'b0}}, operand2_i};

	assign div_by_zero  = (operand2_i == '0);
	assign div_overflow = (operand1_i == exec_pkg::INT_MIN_VALUE) && (operand2_i == '1);

	// keeps the divider away from zero
	assign divisor = div_by_zero ? {{(W-1){1'b0}}, 1'b1} : operand2_i;

	always_comb begin
		quot_s = $signed(operand1_i) / $signed(divisor);
		rem_s  = $signed(operand1_i) % $signed(divisor);
		quot_u = operand1_i / divisor;
		rem_u  = operand1_i % divisor;
		if (div_by_zero) begin
			quot_s = '1;
			rem_s  = operand1_i;
			quot_u = '1;
			rem_u  = operand1_i;
		end else if (div_overflow) begin
			quot_s = exec_pkg::INT_MIN_VALUE;
			rem_s  = '0;
		end
	end

	always_comb begin
		md_result_o = '0;
		if (op_i[exec_pkg::OP_MUL])         md_result_o = prod_uu[W-1:0]; // low word is sign-agnostic
		else if (op_i[exec_pkg::OP_MULH])   md_result_o = prod_ss[2*W-1:W];
		else if (op_i[exec_pkg::OP_MULHSU]) md_result_o = prod_su[2*W-1:W];
		else if (op_i[exec_pkg::OP_MULHU])  md_result_o = prod_uu[2*W-1:W];
		else if (op_i[exec_pkg::OP_DIV])    md_result_o = quot_s;
		else if (op_i[exec_pkg::OP_DIVU])   md_result_o = quot_u;
		else if (op_i[exec_pkg::OP_REM])    md_result_o = rem_s;
		else if (op_i[exec_pkg::OP_REMU])   md_result_o = rem_u;
	end

endmodule

//--- hdl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
	input  logic [exec_pkg::N_OPS-1:0] op_i,
	input  logic [exec_pkg::XLEN-1:0]  operand1_i,
	input  logic [exec_pkg::XLEN-1:0]  operand2_i,
	input  logic [exec_pkg::XLEN-1:0]  imm_i,
	input  logic [exec_pkg::XLEN-1:0]  pc_i,
	output logic [exec_pkg::XLEN-1:0]  alu_result_o
);

	logic [exec_pkg::SHAMT_W-1:0] shamt_reg;
	logic [exec_pkg::SHAMT_W-1:0] shamt_imm;
	logic [exec_pkg::XLEN-1:0]    addr_sum;
	logic                         lt_reg_s;
	logic                         lt_reg_u;
	logic                         lt_imm_s;
	logic                         lt_imm_u;

	assign shamt_reg = operand2_i[exec_pkg::SHAMT_W-1:0]; // low five bits only
	assign shamt_imm = imm_i[exec_pkg::SHAMT_W-1:0];

	// shared by addi, load and store
	assign addr_sum = operand1_i + imm_i;

	assign lt_reg_s = $signed(operand1_i) < $signed(operand2_i);
	assign lt_reg_u = operand1_i < operand2_i;
	assign lt_imm_s = $signed(operand1_i) < $signed(imm_i);
	assign lt_imm_u = operand1_i < imm_i;

	always_comb begin
		alu_result_o = '0;
		if (op_i[exec_pkg::OP_ADD]) begin
			alu_result_o = operand1_i + operand2_i;
		end else if (op_i[exec_pkg::OP_SUB]) begin
			alu_result_o = operand1_i - operand2_i;
		end else if (op_i[exec_pkg::OP_XOR]) begin
			alu_result_o = operand1_i ^ operand2_i;
		end else if (op_i[exec_pkg::OP_OR]) begin
			alu_result_o = operand1_i | operand2_i;
		end else if (op_i[exec_pkg::OP_AND]) begin
			alu_result_o = operand1_i & operand2_i;
		end else if (op_i[exec_pkg::OP_SLL]) begin
			alu_result_o = operand1_i << shamt_reg;
		end else if (op_i[exec_pkg::OP_SRL]) begin
			alu_result_o = operand1_i >> shamt_reg;
		end else if (op_i[exec_pkg::OP_SRA]) begin
			alu_result_o = $signed(operand1_i) >>> shamt_reg;
		end else if (op_i[exec_pkg::OP_SLT]) begin
			alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_reg_s};
		end else if (op_i[exec_pkg::OP_SLTU]) begin
			alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_reg_u};
		end else if (op_i[exec_pkg::OP_ADDI]) begin
			alu_result_o = addr_sum;
		end else if (op_i[exec_pkg::OP_XORI]) begin
			alu_result_o = operand1_i ^ imm_i;
		end else if (op_i[exec_pkg::OP_ORI]) begin
			alu_result_o = operand1_i | imm_i;
		end else if (op_i[exec_pkg::OP_ANDI]) begin
			alu_result_o = operand1_i & imm_i;
		end else if (op_i[exec_pkg::OP_SLLI]) begin
			alu_result_o = operand1_i << shamt_imm;
		end else if (op_i[exec_pkg::OP_SRLI]) begin
			alu_result_o = operand1_i >> shamt_imm;
		end else if (op_i[exec_pkg::OP_SRAI]) begin
			alu_result_o = $signed(operand1_i) >>> shamt_imm;
		end else if (op_i[exec_pkg::OP_SLTI]) begin
			alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_imm_s}; // signed
		end else if (op_i[exec_pkg::OP_SLTIU]) begin
			alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_imm_u}; // unsigned
		end else if (op_i[exec_pkg::OP_LOAD] || op_i[exec_pkg::OP_STORE]) begin
			alu_result_o = addr_sum;
		end else if (op_i[exec_pkg::OP_LUI]) begin
			alu_result_o = imm_i; // decode already shifted it up
		end else if (op_i[exec_pkg::OP_AUIPC]) begin
			alu_result_o = pc_i + imm_i;
		end
	end

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;

	// one-hot operation bits
	localparam int OP_ADD    = 0;
	localparam int OP_SUB    = 1;
	localparam int OP_XOR    = 2;
	localparam int OP_OR     = 3;
	localparam int OP_AND    = 4;
	localparam int OP_SLL    = 5;
	localparam int OP_SRL    = 6;
	localparam int OP_SRA    = 7;
	localparam int OP_SLT    = 8;
	localparam int OP_SLTU   = 9;
	localparam int OP_ADDI   = 10;
	localparam int OP_XORI   = 11;
	localparam int OP_ORI    = 12;
	localparam int OP_ANDI   = 13;
	localparam int OP_SLLI   = 14;
	localparam int OP_SRLI   = 15;
	localparam int OP_SRAI   = 16;
	localparam int OP_SLTI   = 17;
	localparam int OP_SLTIU  = 18;
	localparam int OP_LOAD   = 19; // all load widths
	localparam int OP_STORE  = 20; // all store widths
	localparam int OP_BEQ    = 21; // branches stay contiguous
	localparam int OP_BNE    = 22;
	localparam int OP_BLT    = 23;
	localparam int OP_BGE    = 24;
	localparam int OP_BLTU   = 25;
	localparam int OP_BGEU   = 26;
	localparam int OP_JAL    = 27;
	localparam int OP_JALR   = 28;
	localparam int OP_LUI    = 29;
	localparam int OP_AUIPC  = 30;
	localparam int OP_CSRRW  = 31; // csr group contiguous
	localparam int OP_CSRRS  = 32;
	localparam int OP_CSRRC  = 33;
	localparam int OP_MUL    = 34; // M group contiguous
	localparam int OP_MULH   = 35;
	localparam int OP_MULHSU = 36;
	localparam int OP_MULHU  = 37;
	localparam int OP_DIV    = 38;
	localparam int OP_DIVU   = 39;
	localparam int OP_REM    = 40;
	localparam int OP_REMU   = 41;
	localparam int N_OPS     = OP_REMU + 1;

	localparam int              CNT_W         = 4;
	localparam logic [CNT_W-1:0] MUL_CYCLES   = 4'd7;
	localparam logic [XLEN-1:0] LINK_OFFSET   = 32'd4;
	localparam logic [XLEN-1:0] INT_MIN_VALUE = 32'h8000_0000;

	// multicycle controller states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_COUNT = 2'd1;
	localparam logic [1:0] ST_HOLD  = 2'd2;

endpackage
